// ==== hw/pulse_cfg.svh ====
`ifndef PULSE_CFG_SVH
`define PULSE_CFG_SVH

// power-up parameter set, loaded into the register file on reset
`define PULSE_DEF_PERIOD     1    // frame units
`define PULSE_DEF_P1WIDTH    30   // first pulse, clk cycles
`define PULSE_DEF_P2WIDTH    60   // refocusing pulse width
`define PULSE_DEF_DELAY      200  // tau between pulses
`define PULSE_DEF_PUMP       1    // pulse pin enabled
`define PULSE_DEF_CPMG       1    // one refocusing pulse, plain hahn echo
`define PULSE_DEF_BLOCK      1    // receiver inhibit enabled
`define PULSE_DEF_BLOCKLEAD  50   // train start after frame start
`define PULSE_DEF_BLOCKOFF   100  // inhibit hold after last pulse
`define PULSE_DEF_NUTDEL     300  // gap after nutation pulse
`define PULSE_DEF_NUTWID     300  // nutation pulse width
`define PULSE_DEF_NUT        0    // no nutation pulse

// serial bit time in clk cycles
`define PULSE_CLKS_PER_BIT   16

// clk cycles per step of the period register
`define PULSE_FRAME_UNIT     2048

// sync strobe high time, clk cycles
`define PULSE_SYNC_LEN       4

`endif

// ==== hw/pulse_pkg.sv ====
package pulse_pkg;

	// widths of the parameter fields
	localparam int PERIOD_W = 8;   // frame length in frame units
	localparam int TIME_W   = 16;  // p1 width, delay, p2 width, block-off
	localparam int NUT_W    = 32;  // nutation delay and width
	localparam int COUNT_W  = 8;   // cpmg count, block lead

	// address byte of a host write command
	// command = addr, then four data bytes msb first
	typedef enum logic [7:0] {
		PA_PERIOD    = 8'h00,
		PA_P1WIDTH   = 8'h01,
		PA_DELAY     = 8'h02,
		PA_P2WIDTH   = 8'h03,
		PA_NUTDEL    = 8'h04,
		PA_NUTWID    = 8'h05,
		PA_NUT       = 8'h06,  // nutation enable, bit 0
		PA_PUMP      = 8'h07,  // pulse pin enable, bit 0
		PA_BLOCK     = 8'h08,  // inhibit enable, bit 0
		PA_BLOCKLEAD = 8'h09,
		PA_BLOCKOFF  = 8'h0a,
		PA_CPMG      = 8'h0b   // refocusing pulse count
	} param_addr_e;

	// anything else in the address byte is swallowed without a write

endpackage

// ==== hw/uart_rx.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "pulse_cfg.svh"

// 8n1 receiver, lsb first, sampled at bit centres
module uart_rx (
	input  logic       clk,
	input  logic       resetn,
	input  logic       rx,
	output logic [7:0] rx_byte,
	output logic       rx_strobe
);
	localparam int CPB   = `PULSE_CLKS_PER_BIT;
	localparam int CNT_W = $clog2(CPB);

	localparam logic [1:0] S_IDLE  = 2'd0;
	localparam logic [1:0] S_START = 2'd1;
	localparam logic [1:0] S_DATA  = 2'd2;
	localparam logic [1:0] S_STOP  = 2'd3;

	logic             rx_s1, rx_s2;  // synchronizer
	logic [1:0]       state;
	logic [CNT_W-1:0] tick;          // cycles to next sample point
	logic [2:0]       bit_idx;
	logic             take_bit;

	// line idles high
	always_ff @(posedge clk) begin
		if (resetn) begin
			rx_s1 <= 1'b1;
			rx_s2 <= 1'b1;
		end else begin
			rx_s1 <= rx;
			rx_s2 <= rx_s1;
		end
	end

	assign take_bit = (state == S_DATA) && (tick == '0);

	always_ff @(posedge clk) begin
		if (resetn) begin
			state     <= S_IDLE;
			tick      <= '0;
			bit_idx   <= '0;
			rx_strobe <= 1'b0;
		end else begin
			rx_strobe <= 1'b0;
			case (state)
				S_IDLE: if (!rx_s2) begin  // falling edge of start bit
					state <= S_START;
					tick  <= CNT_W'(CPB / 2 - 1);  // walk to mid start bit
				end
				S_START: begin
					if (tick != '0)
						tick <= tick - 1'b1;
					else if (rx_s2)
						state <= S_IDLE;  // glitch, not a start bit
					else begin
						state   <= S_DATA;
						tick    <= CNT_W'(CPB - 1);
						bit_idx <= '0;
					end
				end
				S_DATA: begin
					if (tick != '0)
						tick <= tick - 1'b1;
					else begin
						tick <= CNT_W'(CPB - 1);
						if (bit_idx == 3'd7)
							state <= S_STOP;
						bit_idx <= bit_idx + 1'b1;
					end
				end
				default: begin  // stop bit
					if (tick != '0)
						tick <= tick - 1'b1;
					else begin
						state     <= S_IDLE;
						rx_strobe <= rx_s2;  // low stop bit drops the byte
					end
				end
			endcase
		end
	end

	// shift in from the top, lsb arrives first
	always_ff @(posedge clk) begin
		if (take_bit)
			rx_byte <= {rx_s2, rx_byte[7:1]};
	end

	// byte strobe is a single cycle
	a_strobe_single: assert property (@(posedge clk) disable iff (resetn)
		rx_strobe |=> !rx_strobe);

endmodule

`default_nettype wire

// ==== hw/param_regs.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "pulse_cfg.svh"

// command assembler and parameter register file
module param_regs (
	input  logic                          clk,
	input  logic                          resetn,
	input  logic [7:0]                    rx_byte,
	input  logic                          rx_strobe,
	output logic [pulse_pkg::PERIOD_W-1:0] period,
	output logic [pulse_pkg::TIME_W-1:0]   p1width,
	output logic [pulse_pkg::TIME_W-1:0]   delay,
	output logic [pulse_pkg::TIME_W-1:0]   p2width,
	output logic [pulse_pkg::NUT_W-1:0]    nut_del,
	output logic [pulse_pkg::NUT_W-1:0]    nut_wid,
	output logic                          nutation,
	output logic                          pump,
	output logic                          block,
	output logic [pulse_pkg::COUNT_W-1:0]  pulse_block,
	output logic [pulse_pkg::TIME_W-1:0]   pulse_block_off,
	output logic [pulse_pkg::COUNT_W-1:0]  cpmg,
	output logic                          rx_done
);
	logic [2:0]             byte_cnt;  // 0 = expecting address
	pulse_pkg::param_addr_e addr;
	logic [23:0]            acc;       // first three data bytes
	logic [31:0]            wdata;
	logic                   wr_en;

	assign wr_en = rx_strobe && (byte_cnt == 3'd4);
	assign wdata = {acc, rx_byte};  // last byte is the lsb

	always_ff @(posedge clk) begin
		if (resetn) begin
			byte_cnt <= '0;
			rx_done  <= 1'b0;
		end else begin
			rx_done <= wr_en;  // also for unknown addresses
			if (rx_strobe)
				byte_cnt <= (byte_cnt == 3'd4) ? 3'd0 : byte_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rx_strobe) begin
			if (byte_cnt == 3'd0)
				addr <= pulse_pkg::param_addr_e'(rx_byte);
			else
				acc <= {acc[15:0], rx_byte};  // msb first
		end
	end

	// registers change on the edge that raises rx_done
	always_ff @(posedge clk) begin
		if (resetn) begin
			period          <= `PULSE_DEF_PERIOD;
			p1width         <= `PULSE_DEF_P1WIDTH;
			delay           <= `PULSE_DEF_DELAY;
			p2width         <= `PULSE_DEF_P2WIDTH;
			nut_del         <= `PULSE_DEF_NUTDEL;
			nut_wid         <= `PULSE_DEF_NUTWID;
			nutation        <= `PULSE_DEF_NUT;
			pump            <= `PULSE_DEF_PUMP;
			block           <= `PULSE_DEF_BLOCK;
			pulse_block     <= `PULSE_DEF_BLOCKLEAD;
			pulse_block_off <= `PULSE_DEF_BLOCKOFF;
			cpmg            <= `PULSE_DEF_CPMG;
		end else if (wr_en) begin
			case (addr)
				pulse_pkg::PA_PERIOD:    period          <= wdata[pulse_pkg::PERIOD_W-1:0];
				pulse_pkg::PA_P1WIDTH:   p1width         <= wdata[pulse_pkg::TIME_W-1:0];
				pulse_pkg::PA_DELAY:     delay           <= wdata[pulse_pkg::TIME_W-1:0];
				pulse_pkg::PA_P2WIDTH:   p2width         <= wdata[pulse_pkg::TIME_W-1:0];
				pulse_pkg::PA_NUTDEL:    nut_del         <= wdata[pulse_pkg::NUT_W-1:0];
				pulse_pkg::PA_NUTWID:    nut_wid         <= wdata[pulse_pkg::NUT_W-1:0];
				pulse_pkg::PA_NUT:       nutation        <= wdata[0];
				pulse_pkg::PA_PUMP:      pump            <= wdata[0];
				pulse_pkg::PA_BLOCK:     block           <= wdata[0];
				pulse_pkg::PA_BLOCKLEAD: pulse_block     <= wdata[pulse_pkg::COUNT_W-1:0];
				pulse_pkg::PA_BLOCKOFF:  pulse_block_off <= wdata[pulse_pkg::TIME_W-1:0];
				pulse_pkg::PA_CPMG:      cpmg            <= wdata[pulse_pkg::COUNT_W-1:0];
				default: ;  // unknown address, nothing written
			endcase
		end
	end

	// every write pulse closes a five byte command
	a_done_after_fifth: assert property (@(posedge clk) disable iff (resetn)
		rx_done |-> $past(rx_strobe) && ($past(byte_cnt) == 3'd4));

endmodule

`default_nettype wire

// ==== hw/pulses.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "pulse_cfg.svh"

// frame timer and pulse train sequencer
module pulses (
	input  logic                          clk,
	input  logic                          resetn,
	input  logic [pulse_pkg::PERIOD_W-1:0] period,
	input  logic [pulse_pkg::TIME_W-1:0]   p1width,
	input  logic [pulse_pkg::TIME_W-1:0]   delay,
	input  logic [pulse_pkg::TIME_W-1:0]   p2width,
	input  logic [pulse_pkg::NUT_W-1:0]    nut_del,
	input  logic [pulse_pkg::NUT_W-1:0]    nut_wid,
	input  logic                          nutation,
	input  logic                          pump,
	input  logic                          block,
	input  logic [pulse_pkg::COUNT_W-1:0]  pulse_block,
	input  logic [pulse_pkg::TIME_W-1:0]   pulse_block_off,
	input  logic [pulse_pkg::COUNT_W-1:0]  cpmg,
	input  logic                          rxd,
	output logic                          sync_on,
	output logic                          pulse_on,
	output logic                          inhib
);
	localparam int PW   = pulse_pkg::PERIOD_W;
	localparam int CW   = pulse_pkg::NUT_W;  // phase counter, widest field
	localparam int FC_W = PW + $clog2(`PULSE_FRAME_UNIT);

	localparam logic [2:0] PH_LEAD   = 3'd0;
	localparam logic [2:0] PH_NUT    = 3'd1;
	localparam logic [2:0] PH_NUTGAP = 3'd2;
	localparam logic [2:0] PH_P1     = 3'd3;
	localparam logic [2:0] PH_GAP    = 3'd4;
	localparam logic [2:0] PH_REF    = 3'd5;
	localparam logic [2:0] PH_TAIL   = 3'd6;
	localparam logic [2:0] PH_DONE   = 3'd7;  // rest of the frame

	// working set, only touched at a frame start
	logic [PW-1:0]                   w_period;
	logic [pulse_pkg::TIME_W-1:0]    w_p1width, w_delay, w_p2width, w_block_off;
	logic [pulse_pkg::NUT_W-1:0]     w_nut_del, w_nut_wid;
	logic                            w_nutation, w_pump, w_block;
	logic [pulse_pkg::COUNT_W-1:0]   w_lead, w_cpmg;

	logic                            pending;  // write seen since last copy
	logic                            take_new;
	logic [pulse_pkg::COUNT_W-1:0]   ld_lead;
	logic [PW-1:0]                   per_eff;
	logic [FC_W-1:0]                 fc, frame_last;
	logic                            wrap;
	logic [2:0]                      phase;
	logic [CW-1:0]                   cnt;      // cycles left in phase after this one
	logic [pulse_pkg::COUNT_W-1:0]   refs;     // refocus pulses left, current included

	// a zero length still takes one cycle
	function automatic logic [CW-1:0] len_m1(input logic [CW-1:0] n);
		len_m1 = (n == '0) ? '0 : n - 1'b1;
	endfunction

	assign per_eff    = (w_period == '0) ? PW'(1) : w_period;
	assign frame_last = FC_W'(per_eff * `PULSE_FRAME_UNIT - 1);
	assign wrap       = (fc == frame_last);
	assign take_new   = resetn || pending || rxd;
	assign ld_lead    = take_new ? pulse_block : w_lead;

	always_ff @(posedge clk) begin
		if (resetn)
			pending <= 1'b0;
		else if (wrap)
			pending <= 1'b0;  // copied now, or nothing to copy
		else if (rxd)
			pending <= 1'b1;
	end

	// copy on the edge into cycle 0, so the new frame sees it whole
	always_ff @(posedge clk) begin
		if (resetn || (wrap && take_new)) begin
			w_period    <= period;
			w_p1width   <= p1width;
			w_delay     <= delay;
			w_p2width   <= p2width;
			w_nut_del   <= nut_del;
			w_nut_wid   <= nut_wid;
			w_nutation  <= nutation;
			w_pump      <= pump;
			w_block     <= block;
			w_lead      <= pulse_block;
			w_block_off <= pulse_block_off;
			w_cpmg      <= cpmg;
		end
	end

	always_ff @(posedge clk) begin
		if (resetn || wrap) begin  // frame start, cuts any running train
			fc    <= '0;
			phase <= PH_LEAD;
			cnt   <= len_m1(CW'(ld_lead));
			refs  <= '0;
		end else begin
			fc <= fc + 1'b1;
			if (cnt != '0)
				cnt <= cnt - 1'b1;
			else begin
				case (phase)
					PH_LEAD: if (w_nutation) begin
						phase <= PH_NUT;
						cnt   <= len_m1(w_nut_wid);
					end else begin
						phase <= PH_P1;
						cnt   <= len_m1(CW'(w_p1width));
					end
					PH_NUT: begin
						phase <= PH_NUTGAP;
						cnt   <= len_m1(w_nut_del);
					end
					PH_NUTGAP: begin
						phase <= PH_P1;
						cnt   <= len_m1(CW'(w_p1width));
					end
					PH_P1: if (w_cpmg != '0) begin
						phase <= PH_GAP;
						cnt   <= len_m1(CW'(w_delay));  // tau before first echo pulse
						refs  <= w_cpmg;
					end else begin
						phase <= PH_TAIL;
						cnt   <= len_m1(CW'(w_block_off));
					end
					PH_GAP: begin
						phase <= PH_REF;
						cnt   <= len_m1(CW'(w_p2width));
					end
					PH_REF: if (refs > 1) begin
						phase <= PH_GAP;
						cnt   <= len_m1(CW'({w_delay, 1'b0}));  // 2 tau between refocus
						refs  <= refs - 1'b1;
					end else begin
						phase <= PH_TAIL;
						cnt   <= len_m1(CW'(w_block_off));
					end
					PH_TAIL: phase <= PH_DONE;
					default: ;  // idle until next frame
				endcase
			end
		end
	end

	// registered outputs, one cycle behind fc and phase
	always_ff @(posedge clk) begin
		if (resetn) begin
			sync_on  <= 1'b0;
			pulse_on <= 1'b0;
			inhib    <= 1'b0;
		end else begin
			sync_on  <= (fc < FC_W'(`PULSE_SYNC_LEN));
			pulse_on <= w_pump && (phase == PH_NUT || phase == PH_P1 || phase == PH_REF);
			inhib    <= w_block && (phase != PH_DONE);  // covers tail as well
		end
	end

	// pump off keeps the pulse pin quiet
	a_pump_off: assert property (@(posedge clk) disable iff (resetn)
		pulse_on |-> $past(w_pump));

	// sync only rises out of frame cycle 0
	a_sync_start: assert property (@(posedge clk) disable iff (resetn)
		$rose(sync_on) |-> ($past(fc) == '0));

endmodule

`default_nettype wire

// ==== hw/pulse_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

// board top: serial in, pulse train out
module pulse_gen (
	input  logic clk,
	input  logic resetn,
	input  logic RS232_Rx,  // from the ftdi bridge
	output logic RS232_Tx,
	output logic Pulse,     // switch drive
	output logic Sync,      // frame strobe
	output logic P2         // receiver inhibit
);
	logic [7:0]                      rx_byte;
	logic                            rx_strobe;
	logic                            rx_done;
	logic [pulse_pkg::PERIOD_W-1:0]  period;
	logic [pulse_pkg::TIME_W-1:0]    p1width, delay, p2width, pulse_block_off;
	logic [pulse_pkg::NUT_W-1:0]     nut_del, nut_wid;
	logic                            nutation, pump, block;
	logic [pulse_pkg::COUNT_W-1:0]   pulse_block, cpmg;

	assign RS232_Tx = 1'b1;  // no transmit path, line idle

	uart_rx i_uart_rx (
		.clk       (clk),
		.resetn    (resetn),
		.rx        (RS232_Rx),
		.rx_byte   (rx_byte),
		.rx_strobe (rx_strobe)
	);

	param_regs i_param_regs (
		.clk             (clk),
		.resetn          (resetn),
		.rx_byte         (rx_byte),
		.rx_strobe       (rx_strobe),
		.period          (period),
		.p1width         (p1width),
		.delay           (delay),
		.p2width         (p2width),
		.nut_del         (nut_del),
		.nut_wid         (nut_wid),
		.nutation        (nutation),
		.pump            (pump),
		.block           (block),
		.pulse_block     (pulse_block),
		.pulse_block_off (pulse_block_off),
		.cpmg            (cpmg),
		.rx_done         (rx_done)
	);

	pulses i_pulses (
		.clk             (clk),
		.resetn          (resetn),
		.period          (period),
		.p1width         (p1width),
		.delay           (delay),
		.p2width         (p2width),
		.nut_del         (nut_del),
		.nut_wid         (nut_wid),
		.nutation        (nutation),
		.pump            (pump),
		.block           (block),
		.pulse_block     (pulse_block),
		.pulse_block_off (pulse_block_off),
		.cpmg            (cpmg),
		.rxd             (rx_done),
		.sync_on         (Sync),
		.pulse_on        (Pulse),
		.inhib           (P2)
	);

endmodule

`default_nettype wire

// ==== bench/pulse_gen_tb.sv ====
`timescale 1ns/1ns
`include "pulse_cfg.svh"

module pulse_gen_tb;
	localparam int CLK_NS   = 40;
	localparam int CPB      = `PULSE_CLKS_PER_BIT;
	localparam int N_TESTS  = 7;
	localparam int MAX_CMD  = 6;
	localparam int MAX_SPAN = 8;   // nutation + p1 + up to 6 refocus

	logic clk;
	logic resetn;
	logic RS232_Rx;
	logic RS232_Tx;
	logic Pulse;
	logic Sync;
	logic P2;

	// stimulus and expected values, one row per test
	string      t_name [N_TESTS];
	int         t_ncmd [N_TESTS];
	logic [7:0] t_addr [N_TESTS][MAX_CMD];
	int         t_data [N_TESTS][MAX_CMD];
	int         exp_frame [N_TESTS];            // frame length in cycles
	int         exp_npulse [N_TESTS];
	int         exp_rise [N_TESTS][MAX_SPAN];   // cycles after sync rise
	int         exp_fall [N_TESTS][MAX_SPAN];   // first low cycle
	int         exp_inh_rise [N_TESTS];         // -1 when inhibit stays low
	int         exp_inh_fall [N_TESTS];

	int          model [12];   // host view of the register file
	logic [31:0] lfsr_state = 32'h34c9;
	bit          table_ready = 1'b0;
	int          err_count = 0;
	int          pass_tests = 0;
	int          fail_tests = 0;

	pulse_gen i_pulse_gen (
		.clk      (clk),
		.resetn   (resetn),
		.RS232_Rx (RS232_Rx),
		.RS232_Tx (RS232_Tx),
		.Pulse    (Pulse),
		.Sync     (Sync),
		.P2       (P2)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic lfsr_step();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic int lfsr_draw(input int nbits);
		int v;
		v = 0;
		for (int i = 0; i < nbits; i++)
			v = (v << 1) | int'(lfsr_step());  // one step per bit
		return v;
	endfunction

	function automatic void add_cmd(input int row, input logic [7:0] addr, input int data);
		t_addr[row][t_ncmd[row]] = addr;
		t_data[row][t_ncmd[row]] = data;
		t_ncmd[row]++;
		if (addr < 8'd12)
			model[addr] = data;  // unknown addresses write nothing
	endfunction

	// one pulse span, clipped at the frame end
	function automatic void add_span(input int row, inout int n, input int rise, input int fall,
			input int f);
		if (model[pulse_pkg::PA_PUMP] != 0 && rise < f && n < MAX_SPAN) begin
			exp_rise[row][n] = rise;
			exp_fall[row][n] = (fall < f) ? fall : f;
			n++;
		end
	endfunction

	// frame rule applied to the current host-side parameter set
	function automatic void expect_row(input int row);
		int f;
		int t;
		int n;
		f = (model[pulse_pkg::PA_PERIOD] == 0) ? 1 : model[pulse_pkg::PA_PERIOD];
		f = f * `PULSE_FRAME_UNIT;
		exp_frame[row] = f;
		n = 0;
		t = model[pulse_pkg::PA_BLOCKLEAD];
		if (model[pulse_pkg::PA_NUT] != 0) begin
			add_span(row, n, t, t + model[pulse_pkg::PA_NUTWID], f);
			t = t + model[pulse_pkg::PA_NUTWID] + model[pulse_pkg::PA_NUTDEL];
		end
		add_span(row, n, t, t + model[pulse_pkg::PA_P1WIDTH], f);
		t = t + model[pulse_pkg::PA_P1WIDTH];
		for (int k = 1; k <= model[pulse_pkg::PA_CPMG]; k++) begin
			t = t + ((k == 1) ? 1 : 2) * model[pulse_pkg::PA_DELAY];  // tau, then 2 tau
			add_span(row, n, t, t + model[pulse_pkg::PA_P2WIDTH], f);
			t = t + model[pulse_pkg::PA_P2WIDTH];
		end
		exp_npulse[row] = n;
		if (model[pulse_pkg::PA_BLOCK] != 0) begin
			exp_inh_rise[row] = 0;
			t = t + model[pulse_pkg::PA_BLOCKOFF];
			exp_inh_fall[row] = (t < f) ? t : f;
		end else begin
			exp_inh_rise[row] = -1;
			exp_inh_fall[row] = -1;
		end
	endfunction

	function automatic void build_table();
		model[pulse_pkg::PA_PERIOD]    = `PULSE_DEF_PERIOD;
		model[pulse_pkg::PA_P1WIDTH]   = `PULSE_DEF_P1WIDTH;
		model[pulse_pkg::PA_DELAY]     = `PULSE_DEF_DELAY;
		model[pulse_pkg::PA_P2WIDTH]   = `PULSE_DEF_P2WIDTH;
		model[pulse_pkg::PA_NUTDEL]    = `PULSE_DEF_NUTDEL;
		model[pulse_pkg::PA_NUTWID]    = `PULSE_DEF_NUTWID;
		model[pulse_pkg::PA_NUT]       = `PULSE_DEF_NUT;
		model[pulse_pkg::PA_PUMP]      = `PULSE_DEF_PUMP;
		model[pulse_pkg::PA_BLOCK]     = `PULSE_DEF_BLOCK;
		model[pulse_pkg::PA_BLOCKLEAD] = `PULSE_DEF_BLOCKLEAD;
		model[pulse_pkg::PA_BLOCKOFF]  = `PULSE_DEF_BLOCKOFF;
		model[pulse_pkg::PA_CPMG]      = `PULSE_DEF_CPMG;
		for (int r = 0; r < N_TESTS; r++)
			t_ncmd[r] = 0;

		t_name[0] = "defaults";  // power-up set, no commands
		expect_row(0);
		t_name[1] = "update";
		add_cmd(1, pulse_pkg::PA_P1WIDTH, 40);
		add_cmd(1, pulse_pkg::PA_DELAY, 150);
		add_cmd(1, pulse_pkg::PA_P2WIDTH, 80);
		add_cmd(1, pulse_pkg::PA_CPMG, 3);
		expect_row(1);
		t_name[2] = "nutation";
		add_cmd(2, pulse_pkg::PA_NUTWID, 120);
		add_cmd(2, pulse_pkg::PA_NUTDEL, 80);
		add_cmd(2, pulse_pkg::PA_NUT, 1);
		expect_row(2);
		t_name[3] = "pump_block_off";
		add_cmd(3, pulse_pkg::PA_PUMP, 0);
		add_cmd(3, pulse_pkg::PA_BLOCK, 0);
		expect_row(3);
		// period 2 gives 4096 cycles, random tau and p1 stay well inside
		t_name[4] = "period_random_a";
		add_cmd(4, pulse_pkg::PA_PUMP, 1);
		add_cmd(4, pulse_pkg::PA_BLOCK, 1);
		add_cmd(4, pulse_pkg::PA_NUT, 0);
		add_cmd(4, pulse_pkg::PA_PERIOD, 2);
		add_cmd(4, pulse_pkg::PA_DELAY, 1 + lfsr_draw(16) % 600);
		add_cmd(4, pulse_pkg::PA_P1WIDTH, 1 + lfsr_draw(16) % 200);
		expect_row(4);
		t_name[5] = "period_random_b";
		add_cmd(5, pulse_pkg::PA_DELAY, 1 + lfsr_draw(16) % 600);
		add_cmd(5, pulse_pkg::PA_P1WIDTH, 1 + lfsr_draw(16) % 200);
		add_cmd(5, pulse_pkg::PA_P2WIDTH, 1 + lfsr_draw(16) % 100);
		expect_row(5);
		t_name[6] = "unknown_addr";
		add_cmd(6, 8'h8b, 5);  // cpmg address with the top bit set
		expect_row(6);
	endfunction

	task automatic check_value(input string test, input string what, input int expected,
			input int actual);
		if (expected !== actual) begin
			$display("CHECK FAILED %s %s: expected %0d, actual %0d",
				test, what, expected, actual);
			err_count++;
		end
	endtask

	// 8n1, lsb first, driven on the falling edge
	task automatic send_byte(input logic [7:0] b);
		@(negedge clk);
		RS232_Rx = 1'b0;  // start bit
		repeat (CPB) @(negedge clk);
		for (int i = 0; i < 8; i++) begin
			RS232_Rx = b[i];
			repeat (CPB) @(negedge clk);
		end
		RS232_Rx = 1'b1;  // stop bit
		repeat (CPB) @(negedge clk);
	endtask

	// returns on the first sample that sees sync high after low
	task automatic wait_sync_rise(input int limit, output bit ok);
		logic prev;
		int   n;
		prev = Sync;
		ok = 1'b0;
		n = 0;
		while (!ok && n < limit) begin
			@(negedge clk);
			n++;
			if (Sync && !prev)
				ok = 1'b1;
			prev = Sync;
		end
	endtask

	// edge recorder over one frame, k counts cycles from the sync rise
	task automatic measure_frame(input int row);
		int   k;
		int   n;
		int   inh_r;
		int   inh_f;
		int   sync_high;
		int   rise [MAX_SPAN];
		int   fall [MAX_SPAN];
		logic p_prev;
		logic i_prev;
		logic s_prev;
		bit   done;
		k = 0;
		n = 0;
		inh_r = -1;
		inh_f = -1;
		sync_high = 0;
		p_prev = 1'b0;
		i_prev = 1'b0;
		s_prev = 1'b0;
		done = 1'b0;
		while (!done) begin
			if (k > 0 && Sync && !s_prev)
				done = 1'b1;  // next frame start
			else if (k > 2 * exp_frame[row])
				done = 1'b1;
			else begin
				if (Sync)
					sync_high++;
				if (Pulse && !p_prev && n < MAX_SPAN)
					rise[n] = k;
				if (!Pulse && p_prev) begin
					if (n < MAX_SPAN)
						fall[n] = k;
					n++;
				end
				if (P2 && !i_prev)
					inh_r = k;
				if (!P2 && i_prev)
					inh_f = k;
				s_prev = Sync;
				p_prev = Pulse;
				i_prev = P2;
				@(negedge clk);
				k++;
			end
		end
		if (k > 2 * exp_frame[row]) begin
			$display("ERROR %s: Sync stopped, no next frame start within %0d cycles",
				t_name[row], 2 * exp_frame[row]);
			err_count++;
		end else begin
			check_value(t_name[row], "frame length", exp_frame[row], k);
			check_value(t_name[row], "sync high cycles", `PULSE_SYNC_LEN, sync_high);
			check_value(t_name[row], "pulse count", exp_npulse[row], n);
			for (int i = 0; i < exp_npulse[row]; i++) begin
				if (i >= n) begin
					$display("ERROR %s: no pulse seen where pulse %0d was expected",
						t_name[row], i);
					err_count++;
				end else begin
					check_value(t_name[row], $sformatf("pulse %0d rise", i),
						exp_rise[row][i], rise[i]);
					check_value(t_name[row], $sformatf("pulse %0d fall", i),
						exp_fall[row][i], fall[i]);
				end
			end
			check_value(t_name[row], "inhibit rise", exp_inh_rise[row], inh_r);
			check_value(t_name[row], "inhibit fall", exp_inh_fall[row], inh_f);
		end
	endtask

	task automatic run_test(input int row);
		int          errs_before;
		bit          ok;
		logic [31:0] data;
		errs_before = err_count;
		for (int c = 0; c < t_ncmd[row]; c++) begin
			data = t_data[row][c];
			send_byte(t_addr[row][c]);
			for (int b = 3; b >= 0; b--)
				send_byte(data[8*b +: 8]);  // msb first
		end
		wait_sync_rise(2 * exp_frame[row] + 16, ok);  // new set copied here
		if (ok)
			wait_sync_rise(2 * exp_frame[row] + 16, ok);  // skipped frame
		if (ok)
			measure_frame(row);
		else begin
			$display("ERROR %s: no Sync rising edge within %0d cycles",
				t_name[row], 2 * exp_frame[row] + 16);
			err_count++;
		end
		check_value(t_name[row], "RS232_Tx idle", 1, int'(RS232_Tx));
		if (err_count == errs_before) begin
			pass_tests++;
			$display("test %0d %s: ok", row, t_name[row]);
		end else begin
			fail_tests++;
			$display("test %0d %s: FAILED with %0d errors",
				row, t_name[row], err_count - errs_before);
		end
	endtask

	initial begin
		resetn   = 1'b1;  // reset level is high
		RS232_Rx = 1'b1;  // line idle
		build_table();
		table_ready = 1'b1;
		repeat (5) @(negedge clk);
		resetn = 1'b0;
		for (int r = 0; r < N_TESTS; r++)
			run_test(r);
		$display("tests run %0d, passed %0d, failed %0d", N_TESTS, pass_tests, fail_tests);
		if (fail_tests == 0 && err_count == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	// per test: serial bytes, then up to three frames
	initial begin
		longint limit;
		wait (table_ready);
		limit = 16;  // reset and start-up slack
		for (int r = 0; r < N_TESTS; r++)
			limit += t_ncmd[r] * 5 * (10 * CPB + 1) + 3 * exp_frame[r] + 64;
		#(limit * CLK_NS);
		$display("timeout: run did not finish within %0d clock cycles", limit);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+hw
hw/pulse_pkg.sv
hw/uart_rx.sv
hw/param_regs.sv
hw/pulses.sv
hw/pulse_gen.sv
bench/pulse_gen_tb.sv

// ==== Makefile ====
RTL = hw/pulse_pkg.sv hw/uart_rx.sv hw/param_regs.sv hw/pulses.sv hw/pulse_gen.sv

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f sim.f \
		--top-module pulse_gen_tb -o pulse_gen_sim

run: build
	./obj_dir/pulse_gen_sim | tee sim.log
	grep -q "\*\*\* TEST PASSED \*\*\*" sim.log

lint:
	verilator --lint-only --timing +incdir+hw $(RTL) --top-module pulse_gen

clean:
	rm -rf obj_dir sim.log
